//--- src/acq_pkg.sv
package acq_pkg;

    localparam int sample_w          = 12;     // bits per adc sample
    localparam int samples_per_burst = 8;      // samples packed into one burst
    localparam int burst_w           = 128;    // payload bits per burst
    localparam int tag_w             = 4;      // word type tag

    typedef logic [tag_w-1:0] tag_t;
    localparam tag_t tag_header = 4'h1;        // fill header word
    localparam tag_t tag_data   = 4'h2;        // adc data word

    // header burst, first field sits at the top of the word
    typedef struct packed {
        logic [23:0] fill_num;                 // fill counter value at trigger
        logic [15:0] channel_tag;              // channel id from the host
        logic [1:0]  fill_type;                // {enable1, enable0}
        logic [10:0] num_bursts;               // data bursts that follow the header
        logic [74:0] pad;                      // zero
    } header_t;

    typedef struct packed {
        logic                ovr;              // over-range flag of this sample
        logic [2:0]          zero;
        logic [sample_w-1:0] sample;
    } adc_slot_t;

    typedef adc_slot_t [samples_per_burst-1:0] adc_burst_t;  // slot 0 oldest, low bits

    // one burst seen either as a header or as eight samples
    typedef union packed {
        header_t    hdr;
        adc_burst_t adc;
    } burst_payload_u;

    typedef struct packed {
        tag_t           tag;                   // says which view of payload applies
        burst_payload_u payload;
    } tagged_word_t;

endpackage

//--- src/mem_pkg.sv
package mem_pkg;

    localparam int burst_addr_w = 11;   // burst address into the store
    localparam int burst_cnt_w  = 12;   // bursts per read request, a full store fits

endpackage

//--- src/adc_sample_packer.sv
module adc_sample_packer import acq_pkg::*; (
    input  logic                clk250,
    input  logic                rst,
    input  logic [sample_w-1:0] adc_data,      // one sample per clock
    input  logic                adc_ovr,
    output adc_burst_t          burst_dat,     // held until the next group completes
    output logic                burst_valid
);

    localparam int cnt_w = $clog2(samples_per_burst);

    adc_slot_t        new_slot;                // incoming sample in slot format
    adc_burst_t       shift_q;                 // newest sample in the top slot
    adc_burst_t       shift_d;
    logic [cnt_w-1:0] sample_cnt;              // position within the group
    logic             group_end;

    assign new_slot  = '{ovr: adc_ovr, zero: 3'b000, sample: adc_data};
    assign shift_d   = {new_slot, shift_q[samples_per_burst-1:1]};  // older ones move down
    assign group_end = (sample_cnt == cnt_w'(samples_per_burst - 1));

    always_ff @(posedge clk250) begin
        shift_q <= shift_d;
        if (group_end)
            burst_dat <= shift_d;              // slot 0 now holds the first sample
    end

    always_ff @(posedge clk250) begin
        if (rst) begin
            sample_cnt  <= '0;
            burst_valid <= 1'b0;
        end else begin
            sample_cnt  <= sample_cnt + 1'b1;  // wraps mod 8
            burst_valid <= group_end;          // one cycle after the 8th sample
        end
    end

endmodule

//--- src/fill_acq_ctrl.sv
module fill_acq_ctrl import acq_pkg::*; (
    input  logic         clk250,
    input  logic         rst,
    input  adc_burst_t   burst_dat,            // stable for 8 cycles after burst_valid
    input  logic         burst_valid,
    input  logic         acq_trig,
    input  logic         acq_enable0,
    input  logic         acq_enable1,
    input  logic [23:0]  initial_fill_num,
    input  logic         initial_fill_num_wr,
    input  logic [15:0]  channel_tag,
    input  logic [10:0]  async_num_bursts,
    input  logic         wr_done,              // writer stored the last data word
    output tagged_word_t fifo_din,
    output logic         fifo_wr_en,
    output logic [23:0]  fill_num,
    output logic         acq_done,
    output logic         acq_idle
);

    localparam logic [2:0] st_idle      = 3'd0;
    localparam logic [2:0] st_armed     = 3'd1;
    localparam logic [2:0] st_header    = 3'd2;
    localparam logic [2:0] st_data      = 3'd3;
    localparam logic [2:0] st_wait_done = 3'd4;

    logic [2:0]  state;
    logic        arm;                          // enabled trigger seen in idle
    logic [1:0]  fill_type_q;
    logic [15:0] channel_tag_q;
    logic [10:0] num_bursts_q;
    logic [10:0] burst_cnt;                    // data words written this fill
    header_t     hdr;

    assign acq_idle = (state == st_idle);
    assign arm      = acq_idle && acq_trig && (acq_enable0 || acq_enable1);

    always_comb begin
        hdr             = '0;
        hdr.fill_num    = fill_num;            // value before the increment
        hdr.channel_tag = channel_tag_q;
        hdr.fill_type   = fill_type_q;
        hdr.num_bursts  = num_bursts_q;
    end

    //////////////////////////////////////////////////////////////////////
    // fill settings and the word toward the FIFO

    always_ff @(posedge clk250) begin
        if (arm) begin
            fill_type_q   <= {acq_enable1, acq_enable0};  // latched at the trigger
            channel_tag_q <= channel_tag;
            num_bursts_q  <= async_num_bursts;
        end
        if (state == st_armed) begin
            fifo_din.tag         <= tag_header;
            fifo_din.payload.hdr <= hdr;
        end else begin
            fifo_din.tag         <= tag_data;
            fifo_din.payload.adc <= burst_dat;  // header state reuses the trigger burst
        end
    end

    //////////////////////////////////////////////////////////////////////
    // fill FSM

    always_ff @(posedge clk250) begin
        if (rst) begin
            state      <= st_idle;
            fifo_wr_en <= 1'b0;
            acq_done   <= 1'b0;
            fill_num   <= '0;
            burst_cnt  <= '0;
        end else begin
            fifo_wr_en <= 1'b0;
            acq_done   <= 1'b0;
            if (initial_fill_num_wr)
                fill_num <= initial_fill_num;
            case (state)
                st_idle: begin
                    if (arm)
                        state <= st_armed;
                end
                st_armed: begin
                    if (burst_valid) begin
                        fifo_wr_en <= 1'b1;     // header word
                        state      <= st_header;
                    end
                end
                st_header: begin
                    fifo_wr_en <= 1'b1;         // same burst as data word 1
                    burst_cnt  <= 11'd1;
                    state      <= (num_bursts_q == 11'd1) ? st_wait_done : st_data;
                end
                st_data: begin
                    if (burst_valid) begin
                        fifo_wr_en <= 1'b1;
                        burst_cnt  <= burst_cnt + 11'd1;
                        if (burst_cnt + 11'd1 == num_bursts_q)
                            state <= st_wait_done;
                    end
                end
                st_wait_done: begin
                    if (wr_done) begin
                        acq_done <= 1'b1;
                        fill_num <= fill_num + 24'd1;  // wins over a host write
                        state    <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

//--- src/burst_fifo.sv
module burst_fifo import acq_pkg::*; #(
    parameter int fifo_depth = 16
) (
    input  logic         clk250,
    input  logic         rst,
    input  tagged_word_t din,
    input  logic         wr_en,
    input  logic         rd_en,
    output tagged_word_t dout,                 // head of the queue, show-ahead
    output logic         empty,
    output logic         fifo_overflow         // sticky until reset
);

    localparam int ptr_w = $clog2(fifo_depth);
    localparam int cnt_w = $clog2(fifo_depth + 1);

    tagged_word_t     buffer [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;                   // occupancy
    logic             full;
    logic             do_wr;
    logic             do_rd;

    assign full  = (count == cnt_w'(fifo_depth));
    assign empty = (count == '0);
    assign do_wr = wr_en && !full;             // word dropped when full
    assign do_rd = rd_en && !empty;
    assign dout  = buffer[rd_ptr];

    always_ff @(posedge clk250) begin
        if (do_wr)
            buffer[wr_ptr] <= din;
    end

    always_ff @(posedge clk250) begin
        if (rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            fifo_overflow <= 1'b0;
        end else begin
            if (do_wr)
                wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // none or both
            endcase
            if (wr_en && full)
                fifo_overflow <= 1'b1;
        end
    end

endmodule

//--- src/ddr3_wr_ctrl.sv
module ddr3_wr_ctrl import acq_pkg::*; import mem_pkg::*; (
    input  logic                    clk250,
    input  logic                    rst,
    input  tagged_word_t            fifo_dout,
    input  logic                    fifo_empty,
    output logic                    fifo_rd_en,
    output logic                    mem_wr_en,
    output logic [burst_addr_w-1:0] mem_wr_addr,
    output logic [burst_w-1:0]      mem_wr_dat,
    output logic                    wr_done    // one cycle after the last data write
);

    logic                    is_header;
    logic                    is_data;
    logic [burst_addr_w-1:0] next_addr;
    logic [burst_addr_w-1:0] expect_cnt;       // data words in this fill
    logic                    last_q;           // last data word is being written

    assign fifo_rd_en = !fifo_empty;           // drain every cycle
    assign is_header  = (fifo_dout.tag == tag_header);
    assign is_data    = (fifo_dout.tag == tag_data);
    assign next_addr  = mem_wr_addr + 1'b1;

    always_ff @(posedge clk250) begin
        if (fifo_rd_en)
            mem_wr_dat <= fifo_dout.payload;   // tag stripped
    end

    always_ff @(posedge clk250) begin
        if (rst) begin
            mem_wr_en   <= 1'b0;
            mem_wr_addr <= '0;
            expect_cnt  <= '0;
            last_q      <= 1'b0;
            wr_done     <= 1'b0;
        end else begin
            mem_wr_en <= fifo_rd_en && (is_header || is_data);
            wr_done   <= last_q;
            last_q    <= 1'b0;
            if (fifo_rd_en && is_header) begin
                mem_wr_addr <= '0;             // header lands at address 0
                expect_cnt  <= fifo_dout.payload.hdr.num_bursts;
            end else if (fifo_rd_en && is_data) begin
                mem_wr_addr <= next_addr;      // data word k at address k
                last_q      <= (next_addr == expect_cnt);
            end
        end
    end

endmodule

//--- src/burst_store.sv
module burst_store import acq_pkg::*; import mem_pkg::*; #(
    parameter int mem_depth = 2048
) (
    input  logic                    clk250,
    input  logic                    wr_en,
    input  logic [burst_addr_w-1:0] wr_addr,
    input  logic [burst_w-1:0]      wr_dat,
    input  logic [burst_addr_w-1:0] rd_addr,
    output logic [burst_w-1:0]      rd_dat     // one cycle after rd_addr
);

    logic [burst_w-1:0] mem [mem_depth];       // stands in for the DDR3

    always_ff @(posedge clk250) begin
        if (wr_en)
            mem[wr_addr] <= wr_dat;
        rd_dat <= mem[rd_addr];
    end

endmodule

//--- src/ddr3_rd_ctrl.sv
module ddr3_rd_ctrl import acq_pkg::*; import mem_pkg::*; (
    input  logic                    clk250,
    input  logic                    rst,
    input  logic                    enable_reading,      // loads start and count, go
    input  logic [burst_addr_w-1:0] ddr3_rd_start_addr,
    input  logic [burst_cnt_w-1:0]  ddr3_rd_burst_cnt,
    output logic [burst_addr_w-1:0] mem_rd_addr,
    input  logic [burst_w-1:0]      mem_rd_dat,
    output logic [burst_w-1:0]      rd_dat,
    output logic                    rd_valid,
    output logic                    rd_last,
    output logic                    reading_done
);

    logic [burst_addr_w-1:0] addr_q;           // next address to issue
    logic [burst_cnt_w-1:0]  remain_q;         // bursts not yet issued
    logic [burst_cnt_w-1:0]  remain_now;
    logic                    issue;            // a read goes out this cycle
    logic                    valid_q;          // memory stage flags
    logic                    last_q;

    // the first read leaves in the enable cycle itself
    assign mem_rd_addr = enable_reading ? ddr3_rd_start_addr : addr_q;
    assign remain_now  = enable_reading ? ddr3_rd_burst_cnt : remain_q;
    assign issue       = (remain_now != '0);

    always_ff @(posedge clk250) begin
        rd_dat <= mem_rd_dat;                  // output stage of the read pipe
    end

    always_ff @(posedge clk250) begin
        if (rst) begin
            addr_q       <= '0;
            remain_q     <= '0;
            valid_q      <= 1'b0;
            last_q       <= 1'b0;
            rd_valid     <= 1'b0;
            rd_last      <= 1'b0;
            reading_done <= 1'b1;
        end else begin
            valid_q  <= issue;
            last_q   <= issue && (remain_now == burst_cnt_w'(1));
            rd_valid <= valid_q;               // lines up with rd_dat
            rd_last  <= last_q;
            if (issue) begin
                addr_q   <= mem_rd_addr + 1'b1;
                remain_q <= remain_now - 1'b1;
            end else begin
                remain_q <= '0;
            end
            if (enable_reading)
                reading_done <= (ddr3_rd_burst_cnt == '0);
            else if (rd_last)
                reading_done <= 1'b1;          // held until the next request
        end
    end

endmodule

//--- src/adc_ddr3_top.sv
module adc_ddr3_top import acq_pkg::*; import mem_pkg::*; #(
    parameter int mem_depth  = 2048,           // bursts in the store
    parameter int fifo_depth = 16              // tagged words in the write FIFO
) (
    input  logic                    clk250,
    input  logic                    rst,
    input  logic [sample_w-1:0]     adc_data,
    input  logic                    adc_ovr,
    input  logic                    acq_trig,
    input  logic                    acq_enable0,
    input  logic                    acq_enable1,
    input  logic [23:0]             initial_fill_num,
    input  logic                    initial_fill_num_wr,
    input  logic [15:0]             channel_tag,
    input  logic [10:0]             async_num_bursts,
    output logic [23:0]             fill_num,
    output logic                    acq_done,
    output logic                    acq_idle,
    output logic                    fifo_overflow,
    input  logic                    enable_reading,
    input  logic [burst_addr_w-1:0] ddr3_rd_start_addr,
    input  logic [burst_cnt_w-1:0]  ddr3_rd_burst_cnt,
    output logic [burst_w-1:0]      rd_dat,
    output logic                    rd_valid,
    output logic                    rd_last,
    output logic                    reading_done
);

    adc_burst_t              burst_dat;        // packer to fill controller
    logic                    burst_valid;
    tagged_word_t            fifo_din;
    logic                    fifo_wr_en;
    tagged_word_t            fifo_dout;
    logic                    fifo_empty;
    logic                    fifo_rd_en;
    logic                    wr_done;
    logic                    mem_wr_en;
    logic [burst_addr_w-1:0] mem_wr_addr;
    logic [burst_w-1:0]      mem_wr_dat;
    logic [burst_addr_w-1:0] mem_rd_addr;
    logic [burst_w-1:0]      mem_rd_dat;

    //////////////////////////////////////////////////////////////////////
    // acquisition side

    adc_sample_packer adc_sample_packer_inst (
        .clk250(clk250), .rst(rst),
        .adc_data(adc_data), .adc_ovr(adc_ovr),
        .burst_dat(burst_dat), .burst_valid(burst_valid)
    );

    fill_acq_ctrl fill_acq_ctrl_inst (
        .clk250(clk250), .rst(rst),
        .burst_dat(burst_dat), .burst_valid(burst_valid),
        .acq_trig(acq_trig), .acq_enable0(acq_enable0), .acq_enable1(acq_enable1),
        .initial_fill_num(initial_fill_num), .initial_fill_num_wr(initial_fill_num_wr),
        .channel_tag(channel_tag), .async_num_bursts(async_num_bursts),
        .wr_done(wr_done),
        .fifo_din(fifo_din), .fifo_wr_en(fifo_wr_en),
        .fill_num(fill_num), .acq_done(acq_done), .acq_idle(acq_idle)
    );

    burst_fifo #(.fifo_depth(fifo_depth)) burst_fifo_inst (
        .clk250(clk250), .rst(rst),
        .din(fifo_din), .wr_en(fifo_wr_en), .rd_en(fifo_rd_en),
        .dout(fifo_dout), .empty(fifo_empty), .fifo_overflow(fifo_overflow)
    );

    //////////////////////////////////////////////////////////////////////
    // memory side

    ddr3_wr_ctrl ddr3_wr_ctrl_inst (
        .clk250(clk250), .rst(rst),
        .fifo_dout(fifo_dout), .fifo_empty(fifo_empty), .fifo_rd_en(fifo_rd_en),
        .mem_wr_en(mem_wr_en), .mem_wr_addr(mem_wr_addr), .mem_wr_dat(mem_wr_dat),
        .wr_done(wr_done)
    );

    burst_store #(.mem_depth(mem_depth)) burst_store_inst (
        .clk250(clk250),
        .wr_en(mem_wr_en), .wr_addr(mem_wr_addr), .wr_dat(mem_wr_dat),
        .rd_addr(mem_rd_addr), .rd_dat(mem_rd_dat)
    );

    ddr3_rd_ctrl ddr3_rd_ctrl_inst (
        .clk250(clk250), .rst(rst),
        .enable_reading(enable_reading),
        .ddr3_rd_start_addr(ddr3_rd_start_addr), .ddr3_rd_burst_cnt(ddr3_rd_burst_cnt),
        .mem_rd_addr(mem_rd_addr), .mem_rd_dat(mem_rd_dat),
        .rd_dat(rd_dat), .rd_valid(rd_valid), .rd_last(rd_last),
        .reading_done(reading_done)
    );

endmodule

//--- tb/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk                            // free running clk250
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam realtime half_period = 2.0;      // 4 ns period, 250 MHz

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

endmodule

//--- tb/adc_ddr3_tb.sv
module adc_ddr3_tb import acq_pkg::*; import mem_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int mem_depth    = 2048;
    localparam int fifo_depth   = 16;
    localparam int done_timeout = 300;          // cycles from trigger to acq_done
    localparam int idle_window  = 100;          // cycles a rejected trigger is watched
    localparam int rd_timeout   = 64;           // cycles for one read request
    localparam int n_rows       = 7;

    typedef struct packed {
        logic        load;                      // write initial_fill_num first
        logic [23:0] init_val;
        logic        en1;
        logic        en0;
        logic [10:0] nb;                        // async_num_bursts
        logic        accept;                    // fill expected to run
    } row_t;

    // load, init value, enable1, enable0, bursts, accepted
    localparam row_t rows [n_rows] = '{
        '{1'b1, 24'h000010, 1'b0, 1'b1, 11'd3, 1'b1},
        '{1'b0, 24'h000000, 1'b1, 1'b0, 11'd1, 1'b1},
        '{1'b0, 24'h000000, 1'b0, 1'b0, 11'd4, 1'b0},  // both enables clear
        '{1'b1, 24'hfffffe, 1'b1, 1'b1, 11'd5, 1'b1},
        '{1'b0, 24'h000000, 1'b1, 1'b1, 11'd2, 1'b1},  // counter wraps here
        '{1'b0, 24'h000000, 1'b0, 1'b0, 11'd2, 1'b0},
        '{1'b0, 24'h000000, 1'b0, 1'b1, 11'd8, 1'b1}
    };

    logic                    clk250;
    logic                    rst;
    logic [sample_w-1:0]     adc_data = '0;     // ramp source
    logic                    adc_ovr  = 1'b0;
    logic [sample_w-1:0]     ramp_next;
    logic                    acq_trig;
    logic                    acq_enable0;
    logic                    acq_enable1;
    logic [23:0]             initial_fill_num;
    logic                    initial_fill_num_wr;
    logic [15:0]             channel_tag;
    logic [10:0]             async_num_bursts;
    logic [23:0]             fill_num;
    logic                    acq_done;
    logic                    acq_idle;
    logic                    fifo_overflow;
    logic                    enable_reading;
    logic [burst_addr_w-1:0] ddr3_rd_start_addr;
    logic [burst_cnt_w-1:0]  ddr3_rd_burst_cnt;
    logic [burst_w-1:0]      rd_dat;
    logic                    rd_valid;
    logic                    rd_last;
    logic                    reading_done;

    int                      errors   = 0;
    int                      checks   = 0;
    int                      timeouts = 0;
    logic [23:0]             exp_fill = '0;     // fill_num expected next
    logic [burst_w-1:0]      beats [64];        // bursts of the last read

    tb_clock_gen clock_gen_inst (.clk(clk250));

    adc_ddr3_top #(.mem_depth(mem_depth), .fifo_depth(fifo_depth)) adc_ddr3_top_inst (
        .clk250(clk250), .rst(rst),
        .adc_data(adc_data), .adc_ovr(adc_ovr),
        .acq_trig(acq_trig), .acq_enable0(acq_enable0), .acq_enable1(acq_enable1),
        .initial_fill_num(initial_fill_num), .initial_fill_num_wr(initial_fill_num_wr),
        .channel_tag(channel_tag), .async_num_bursts(async_num_bursts),
        .fill_num(fill_num), .acq_done(acq_done), .acq_idle(acq_idle),
        .fifo_overflow(fifo_overflow),
        .enable_reading(enable_reading),
        .ddr3_rd_start_addr(ddr3_rd_start_addr), .ddr3_rd_burst_cnt(ddr3_rd_burst_cnt),
        .rd_dat(rd_dat), .rd_valid(rd_valid), .rd_last(rd_last),
        .reading_done(reading_done)
    );

    //////////////////////////////////////////////////////////////////////
    // adc ramp, first sample after reset lands in slot 0

    assign ramp_next = adc_data + 12'd1;

    always @(posedge clk250) begin
        if (rst) begin
            adc_data <= '0;
            adc_ovr  <= 1'b0;
        end else begin
            adc_data <= ramp_next;
            adc_ovr  <= ramp_next[4];           // over-range follows bit 4
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks and bus tasks

    task automatic check_val(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic read_range(input int start, input int cnt);
        int beat;
        int cyc;
        beat = 0;
        @(posedge clk250);
        ddr3_rd_start_addr <= burst_addr_w'(start);
        ddr3_rd_burst_cnt  <= burst_cnt_w'(cnt);
        enable_reading     <= 1'b1;             // one cycle pulse
        @(posedge clk250);
        enable_reading     <= 1'b0;
        for (cyc = 1; cyc <= rd_timeout && beat < cnt; cyc++) begin
            @(negedge clk250);
            if (rd_valid) begin
                if (beat == 0)
                    check_val("first rd_valid delay", 128'(cyc), 128'(2));
                check_val("rd_last", 128'(rd_last), 128'(beat == cnt - 1));
                check_val("reading_done during read", 128'(reading_done), 128'(0));
                beats[beat] = rd_dat;
                beat++;
            end else begin
                check_val("rd_last", 128'(rd_last), 128'(0));  // never without a beat
            end
        end
        if (beat < cnt) begin
            $display("timeout: read of %0d bursts from address %0d gave %0d beats",
                     cnt, start, beat);
            timeouts++;
        end
        @(negedge clk250);
        check_val("rd_valid after last beat", 128'(rd_valid), 128'(0));
        check_val("reading_done", 128'(reading_done), 128'(1));
    endtask

    task automatic check_ramp(input int nb);
        burst_payload_u      pl;
        logic [sample_w-1:0] prev;
        logic [sample_w-1:0] smp;
        logic [sample_w-1:0] want;
        logic                first;
        first = 1'b1;
        prev  = '0;
        for (int b = 1; b <= nb; b++) begin
            pl = beats[b];                      // data view of the burst
            check_val($sformatf("rd_dat burst %0d slot 0 alignment", b),
                      128'(pl.adc[0].sample[2:0]), 128'(0));
            for (int s = 0; s < samples_per_burst; s++) begin
                smp  = pl.adc[s].sample;
                want = prev + 12'd1;            // wraps mod 4096
                if (!first)
                    check_val($sformatf("rd_dat burst %0d slot %0d sample", b, s),
                              128'(smp), 128'(want));
                check_val($sformatf("rd_dat burst %0d slot %0d ovr", b, s),
                          128'(pl.adc[s].ovr), 128'(smp[4]));
                check_val($sformatf("rd_dat burst %0d slot %0d zero", b, s),
                          128'(pl.adc[s].zero), 128'(0));
                first = 1'b0;
                prev  = smp;
            end
        end
    endtask

    task automatic run_row(input int r);
        row_t               row;
        logic [15:0]        tag;
        logic [23:0]        next_fill;
        int                 nb;
        int                 cyc;
        logic               seen_done;
        logic               left_idle;
        burst_payload_u     pl;
        logic [burst_w-1:0] bulk [64];
        row = rows[r];
        nb  = int'(row.nb);
        tag = 16'($urandom());
        if (row.load) begin
            @(posedge clk250);
            initial_fill_num    <= row.init_val;
            initial_fill_num_wr <= 1'b1;
            @(posedge clk250);
            initial_fill_num_wr <= 1'b0;
            exp_fill = row.init_val;
        end
        @(negedge clk250);
        check_val("fill_num before trigger", 128'(fill_num), 128'(exp_fill));
        @(posedge clk250);
        channel_tag      <= tag;
        acq_enable0      <= row.en0;
        acq_enable1      <= row.en1;
        async_num_bursts <= row.nb;
        acq_trig         <= 1'b1;
        @(posedge clk250);
        acq_trig         <= 1'b0;
        seen_done = 1'b0;
        left_idle = 1'b0;
        if (!row.accept) begin
            for (cyc = 0; cyc < idle_window; cyc++) begin
                @(negedge clk250);
                seen_done |= acq_done;
                left_idle |= !acq_idle;
            end
            check_val("acq_done on disabled trigger", 128'(seen_done), 128'(0));
            check_val("acq_idle dropped", 128'(left_idle), 128'(0));
            check_val("fill_num", 128'(fill_num), 128'(exp_fill));
        end else begin
            for (cyc = 0; cyc < done_timeout && !seen_done; cyc++) begin
                @(negedge clk250);
                seen_done = acq_done;
                left_idle |= !acq_idle;
            end
            if (!seen_done) begin
                $display("timeout: no acq_done within %0d cycles for row %0d", done_timeout, r);
                timeouts++;
                return;
            end
            check_val("acq_idle dropped during fill", 128'(left_idle), 128'(1));
            check_val("acq_idle with acq_done", 128'(acq_idle), 128'(1));
            next_fill = exp_fill + 24'd1;
            check_val("fill_num after acq_done", 128'(fill_num), 128'(next_fill));
            read_range(0, nb + 1);              // header and all data bursts
            pl = beats[0];                      // header view
            check_val("hdr.fill_num", 128'(pl.hdr.fill_num), 128'(exp_fill));
            check_val("hdr.channel_tag", 128'(pl.hdr.channel_tag), 128'(tag));
            check_val("hdr.fill_type", 128'(pl.hdr.fill_type), 128'({row.en1, row.en0}));
            check_val("hdr.num_bursts", 128'(pl.hdr.num_bursts), 128'(row.nb));
            check_val("hdr.pad", 128'(pl.hdr.pad), 128'(0));
            check_ramp(nb);
            exp_fill = next_fill;
            for (int a = 0; a <= nb; a++)
                bulk[a] = beats[a];
            for (int a = 0; a <= nb; a++) begin
                read_range(a, 1);               // same burst, one address at a time
                check_val($sformatf("rd_dat single read at %0d", a), beats[0], bulk[a]);
            end
        end
        check_val("fifo_overflow", 128'(fifo_overflow), 128'(0));
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        void'($urandom(32'h9065));
        rst                 = 1'b1;
        acq_trig            = 1'b0;
        acq_enable0         = 1'b0;
        acq_enable1         = 1'b0;
        initial_fill_num    = '0;
        initial_fill_num_wr = 1'b0;
        channel_tag         = '0;
        async_num_bursts    = '0;
        enable_reading      = 1'b0;
        ddr3_rd_start_addr  = '0;
        ddr3_rd_burst_cnt   = '0;
        repeat (5) @(posedge clk250);
        rst <= 1'b0;
        @(negedge clk250);
        check_val("acq_done", 128'(acq_done), 128'(0));     // state right after reset
        check_val("acq_idle", 128'(acq_idle), 128'(1));
        check_val("rd_valid", 128'(rd_valid), 128'(0));
        check_val("rd_last", 128'(rd_last), 128'(0));
        check_val("reading_done", 128'(reading_done), 128'(1));
        check_val("fifo_overflow", 128'(fifo_overflow), 128'(0));
        repeat (20) @(posedge clk250);          // let the packer fill its first groups
        for (int r = 0; r < n_rows; r++)
            run_row(r);
        $display("checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

//--- flist.f
src/acq_pkg.sv
src/mem_pkg.sv
src/adc_sample_packer.sv
src/fill_acq_ctrl.sv
src/burst_fifo.sv
src/ddr3_wr_ctrl.sv
src/burst_store.sv
src/ddr3_rd_ctrl.sv
src/adc_ddr3_top.sv
tb/tb_clock_gen.sv
tb/adc_ddr3_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
TOP       := adc_ddr3_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)
